// File: source/csd_pkg.sv
/*
 * Shared widths, lane count and default CSD digit masks for the multiplier bank,
 * the per-lane term row type and a digit counting helper
 */
package csd_pkg;

    localparam int sample_w  = 16;
    localparam int prod_w    = 32;
    localparam int coef_w    = 12;  // Largest coefficient magnitude fits 12 bits signed
    localparam int num_lanes = 4;
    localparam int digit_w   = 16;
    localparam int max_terms = 6;

    // -835 = 2^8 + 2^0 - 2^10 - 2^6 - 2^2
    localparam logic [digit_w-1:0] lane0_pos = 16'h0101;
    localparam logic [digit_w-1:0] lane0_neg = 16'h0444;

    // -146 = -2^7 - 2^4 - 2^1
    localparam logic [digit_w-1:0] lane1_pos = 16'h0000;
    localparam logic [digit_w-1:0] lane1_neg = 16'h0092;

    // 1221 = 2^10 + 2^8 + 2^2 + 2^0 - 2^6
    localparam logic [digit_w-1:0] lane2_pos = 16'h0505;
    localparam logic [digit_w-1:0] lane2_neg = 16'h0040;

    // 367 = 2^9 - 2^7 - 2^4 - 2^0
    localparam logic [digit_w-1:0] lane3_pos = 16'h0200;
    localparam logic [digit_w-1:0] lane3_neg = 16'h0091;

    typedef logic [max_terms-1:0][prod_w-1:0] term_rows;

    // Number of set bits in mask below bit position pos
    function automatic int ones_below(logic [digit_w-1:0] mask, int pos);
        int n;
        n = 0;
        for (int i = 0; i < digit_w; i++) begin
            if (i < pos && mask[i]) begin
                n++;
            end
        end
        return n;
    endfunction

endpackage

// File: source/term_gen.sv
/*
 * Input stage of the CSD multiplier bank.
 * Sign-extends the sample, forms shifted and inverted CSD terms per lane
 * and registers them with the valid strobe.
 */
module term_gen #(
    parameter logic [csd_pkg::num_lanes-1:0][csd_pkg::digit_w-1:0] pos_masks = {
        csd_pkg::lane3_pos, csd_pkg::lane2_pos, csd_pkg::lane1_pos, csd_pkg::lane0_pos
    },
    parameter logic [csd_pkg::num_lanes-1:0][csd_pkg::digit_w-1:0] neg_masks = {
        csd_pkg::lane3_neg, csd_pkg::lane2_neg, csd_pkg::lane1_neg, csd_pkg::lane0_neg
    }
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic signed [csd_pkg::sample_w-1:0]       x,
    input  logic                                      in_valid,
    output csd_pkg::term_rows [csd_pkg::num_lanes-1:0] terms,
    output logic                                      term_valid
);

    localparam int ext_w = csd_pkg::prod_w - csd_pkg::sample_w;

    logic [csd_pkg::prod_w-1:0]                x_ext;
    csd_pkg::term_rows [csd_pkg::num_lanes-1:0] term_d;

    assign x_ext = {{ext_w{x[csd_pkg::sample_w-1]}}, x};

    for (genvar l = 0; l < csd_pkg::num_lanes; l++) begin : g_lane
        localparam logic [csd_pkg::digit_w-1:0] used = pos_masks[l] | neg_masks[l];
        localparam int n_used = csd_pkg::ones_below(used, csd_pkg::digit_w);

        // Each nonzero digit lands in the next free slot, lowest digit first
        for (genvar k = 0; k < csd_pkg::digit_w; k++) begin : g_digit
            if (used[k] && csd_pkg::ones_below(used, k) < csd_pkg::max_terms) begin : g_term
                localparam int slot = csd_pkg::ones_below(used, k);
                if (neg_masks[l][k]) begin : g_neg
                    assign term_d[l][slot] = ~(x_ext << k);  // +1 added in csa_tree
                end else begin : g_pos
                    assign term_d[l][slot] = x_ext << k;
                end
            end
        end

        for (genvar s = 0; s < csd_pkg::max_terms; s++) begin : g_pad
            if (s >= n_used) begin : g_zero
                assign term_d[l][s] = '0;
            end
        end

        a_no_overlap: assert property (@(posedge clk) (pos_masks[l] & neg_masks[l]) == '0)
            else $error("lane %0d has a digit in both masks", l);

        a_csd_form: assert property (@(posedge clk) (used & (used << 1)) == '0)
            else $error("lane %0d has adjacent nonzero digits", l);

        a_term_count: assert property (@(posedge clk) n_used <= csd_pkg::max_terms)
            else $error("lane %0d needs %0d terms", l, n_used);
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            terms <= term_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            term_valid <= 1'b0;
        end else begin
            term_valid <= in_valid;
        end
    end

    a_x_known: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(x))
        else $error("in_valid with unknown sample");

endmodule

// File: source/csa_tree.sv
/*
 * Carry-save reduction per lane.
 * Adds the inversion correction row and compresses all rows with
 * 3:2 compressor levels down to a registered sum row and carry row.
 */
module csa_tree #(
    parameter logic [csd_pkg::num_lanes-1:0][csd_pkg::digit_w-1:0] neg_masks = {
        csd_pkg::lane3_neg, csd_pkg::lane2_neg, csd_pkg::lane1_neg, csd_pkg::lane0_neg
    }
) (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  csd_pkg::term_rows [csd_pkg::num_lanes-1:0]          terms,
    input  logic                                               term_valid,
    output logic [csd_pkg::num_lanes-1:0][csd_pkg::prod_w-1:0] sum_row,
    output logic [csd_pkg::num_lanes-1:0][csd_pkg::prod_w-1:0] carry_row,
    output logic                                               tree_valid
);

    localparam int n_rows = csd_pkg::max_terms + 1;  // Terms plus correction row

    // Rows left after a given number of compressor levels
    function automatic int rows_at(int level);
        int n;
        n = n_rows;
        for (int i = 0; i < level; i++) begin
            n = n - n / 3;
        end
        return n;
    endfunction

    function automatic int levels_needed();
        int lvl;
        lvl = 0;
        for (int i = 0; i < n_rows; i++) begin
            if (rows_at(i) > 2) begin
                lvl = i + 1;
            end
        end
        return lvl;
    endfunction

    localparam int n_levels = levels_needed();

    logic [csd_pkg::num_lanes-1:0][csd_pkg::prod_w-1:0] sum_d;
    logic [csd_pkg::num_lanes-1:0][csd_pkg::prod_w-1:0] carry_d;

    for (genvar l = 0; l < csd_pkg::num_lanes; l++) begin : g_lane
        // One +1 for every inverted term
        localparam logic [csd_pkg::prod_w-1:0] corr =
            csd_pkg::ones_below(neg_masks[l], csd_pkg::digit_w);

        logic [csd_pkg::prod_w-1:0] node [n_levels+1][n_rows];
        logic [csd_pkg::prod_w-1:0] row_total;  // Sum of all input rows

        for (genvar r = 0; r < csd_pkg::max_terms; r++) begin : g_in
            assign node[0][r] = terms[l][r];
        end
        assign node[0][csd_pkg::max_terms] = corr;

        for (genvar v = 0; v < n_levels; v++) begin : g_level
            localparam int cnt = rows_at(v);
            localparam int grp = cnt / 3;

            for (genvar g = 0; g < grp; g++) begin : g_csa
                assign node[v+1][2*g] = node[v][3*g] ^ node[v][3*g+1] ^ node[v][3*g+2];
                assign node[v+1][2*g+1] = ((node[v][3*g] & node[v][3*g+1]) |
                                           (node[v][3*g+1] & node[v][3*g+2]) |
                                           (node[v][3*g] & node[v][3*g+2])) << 1;
            end

            for (genvar r = 3 * grp; r < cnt; r++) begin : g_pass
                assign node[v+1][r - grp] = node[v][r];  // Leftover rows skip this level
            end

            for (genvar r = cnt - grp; r < n_rows; r++) begin : g_idle
                assign node[v+1][r] = '0;
            end
        end

        assign sum_d[l]   = node[n_levels][0];
        assign carry_d[l] = node[n_levels][1];

        always_comb begin
            row_total = '0;
            for (int r = 0; r < n_rows; r++) begin
                row_total = row_total + node[0][r];
            end
        end

        // Compressors keep the total of all rows modulo 2^prod_w
        a_sum_kept: assert property (@(posedge clk) disable iff (!rst_n)
            term_valid |-> (sum_d[l] + carry_d[l]) == row_total)
            else $error("lane %0d rows lost in reduction", l);
    end

    always_ff @(posedge clk) begin
        if (term_valid) begin
            sum_row   <= sum_d;
            carry_row <= carry_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tree_valid <= 1'b0;
        end else begin
            tree_valid <= term_valid;
        end
    end

endmodule

// File: source/carry_prop_stage.sv
/*
 * Output stage of the multiplier bank.
 * Carry-propagate add of each lane's sum and carry rows into the registered products.
 */
module carry_prop_stage (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic [csd_pkg::num_lanes-1:0][csd_pkg::prod_w-1:0] sum_row,
    input  logic [csd_pkg::num_lanes-1:0][csd_pkg::prod_w-1:0] carry_row,
    input  logic                                               tree_valid,
    output logic signed [csd_pkg::prod_w-1:0]                  y0,
    output logic signed [csd_pkg::prod_w-1:0]                  y1,
    output logic signed [csd_pkg::prod_w-1:0]                  y2,
    output logic signed [csd_pkg::prod_w-1:0]                  y3,
    output logic                                               out_valid
);

    // Significant width of any product of a sample and a lane coefficient
    localparam int used_w = csd_pkg::sample_w + csd_pkg::coef_w;

    logic [csd_pkg::num_lanes-1:0][csd_pkg::prod_w-1:0] y_q;

    always_ff @(posedge clk) begin
        if (tree_valid) begin
            for (int l = 0; l < csd_pkg::num_lanes; l++) begin
                y_q[l] <= sum_row[l] + carry_row[l];  // Wraps mod 2^prod_w
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= tree_valid;
        end
    end

    assign y0 = y_q[0];
    assign y1 = y_q[1];
    assign y2 = y_q[2];
    assign y3 = y_q[3];

    for (genvar l = 0; l < csd_pkg::num_lanes; l++) begin : g_range
        a_sign_ext: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid |-> (&y_q[l][csd_pkg::prod_w-1:used_w-1] ||
                           ~|y_q[l][csd_pkg::prod_w-1:used_w-1]))
            else $error("lane %0d product out of range: %h", l, y_q[l]);
    end

endmodule

// File: source/csd_mult_bank.sv
/*
 * Top level of the four-lane CSD constant multiplier bank.
 * Term generation, carry-save tree and carry-propagate stage, three cycles in total.
 */
module csd_mult_bank #(
    parameter logic [csd_pkg::digit_w-1:0] lane0_pos = csd_pkg::lane0_pos,
    parameter logic [csd_pkg::digit_w-1:0] lane1_pos = csd_pkg::lane1_pos,
    parameter logic [csd_pkg::digit_w-1:0] lane2_pos = csd_pkg::lane2_pos,
    parameter logic [csd_pkg::digit_w-1:0] lane3_pos = csd_pkg::lane3_pos,
    parameter logic [csd_pkg::digit_w-1:0] lane0_neg = csd_pkg::lane0_neg,
    parameter logic [csd_pkg::digit_w-1:0] lane1_neg = csd_pkg::lane1_neg,
    parameter logic [csd_pkg::digit_w-1:0] lane2_neg = csd_pkg::lane2_neg,
    parameter logic [csd_pkg::digit_w-1:0] lane3_neg = csd_pkg::lane3_neg
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic signed [csd_pkg::sample_w-1:0] x,
    input  logic                                in_valid,
    output logic signed [csd_pkg::prod_w-1:0]   y0,
    output logic signed [csd_pkg::prod_w-1:0]   y1,
    output logic signed [csd_pkg::prod_w-1:0]   y2,
    output logic signed [csd_pkg::prod_w-1:0]   y3,
    output logic                                out_valid
);

    localparam logic [csd_pkg::num_lanes-1:0][csd_pkg::digit_w-1:0] pos_masks = {
        lane3_pos, lane2_pos, lane1_pos, lane0_pos
    };
    localparam logic [csd_pkg::num_lanes-1:0][csd_pkg::digit_w-1:0] neg_masks = {
        lane3_neg, lane2_neg, lane1_neg, lane0_neg
    };

    csd_pkg::term_rows [csd_pkg::num_lanes-1:0]         terms;
    logic                                               term_valid;
    logic [csd_pkg::num_lanes-1:0][csd_pkg::prod_w-1:0] sum_row;
    logic [csd_pkg::num_lanes-1:0][csd_pkg::prod_w-1:0] carry_row;
    logic                                               tree_valid;

    term_gen #(
        .pos_masks (pos_masks),
        .neg_masks (neg_masks)
    ) term_gen_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .x          (x),
        .in_valid   (in_valid),
        .terms      (terms),
        .term_valid (term_valid)
    );

    csa_tree #(
        .neg_masks (neg_masks)  // Sizes the correction row
    ) csa_tree_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .terms      (terms),
        .term_valid (term_valid),
        .sum_row    (sum_row),
        .carry_row  (carry_row),
        .tree_valid (tree_valid)
    );

    carry_prop_stage carry_prop_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .sum_row    (sum_row),
        .carry_row  (carry_row),
        .tree_valid (tree_valid),
        .y0         (y0),
        .y1         (y1),
        .y2         (y2),
        .y3         (y3),
        .out_valid  (out_valid)
    );

endmodule

// File: verification/tb_csd_mult_bank.sv
/*
 * Testbench for the CSD multiplier bank with random and corner stimulus,
 * a pipeline model of expected products, per-test report and timeout
 */
module tb_csd_mult_bank;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int stim_cycles = 460;
    localparam int cycle_limit = 2 * stim_cycles + 50;

    logic                                clk;
    logic                                rst_n;
    logic signed [csd_pkg::sample_w-1:0] x;
    logic                                in_valid;
    logic signed [csd_pkg::prod_w-1:0]   y0;
    logic signed [csd_pkg::prod_w-1:0]   y1;
    logic signed [csd_pkg::prod_w-1:0]   y2;
    logic signed [csd_pkg::prod_w-1:0]   y3;
    logic                                out_valid;

    logic [csd_pkg::prod_w-1:0]          y_all [csd_pkg::num_lanes];
    int                                  coef [csd_pkg::num_lanes];
    logic                                pipe_v [3];  // Model of the three valid stages
    logic signed [csd_pkg::sample_w-1:0] pipe_x [3];
    logic [csd_pkg::sample_w-1:0]        corners [5];
    integer                              seed;
    int                                  err_count;
    int                                  pass_count;
    int                                  fail_count;
    int                                  cycle_count;
    int                                  test_start;

    csd_mult_bank csd_mult_bank_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .x         (x),
        .in_valid  (in_valid),
        .y0        (y0),
        .y1        (y1),
        .y2        (y2),
        .y3        (y3),
        .out_valid (out_valid)
    );

    assign y_all[0] = y0;
    assign y_all[1] = y1;
    assign y_all[2] = y2;
    assign y_all[3] = y3;

    // Coefficient is the sum of pos digit weights minus neg digit weights
    function automatic int coef_from_masks(logic [csd_pkg::digit_w-1:0] pos,
                                           logic [csd_pkg::digit_w-1:0] neg);
        int c;
        c = 0;
        for (int k = 0; k < csd_pkg::digit_w; k++) begin
            if (pos[k]) begin
                c = c + (1 << k);
            end
            if (neg[k]) begin
                c = c - (1 << k);
            end
        end
        return c;
    endfunction

    function automatic logic [31:0] expected_product(logic signed [15:0] s, int c);
        longint p;
        p = longint'(s) * longint'(c);
        return p[31:0];
    endfunction

    task automatic drive_cycle(input logic v, input logic [15:0] value);
        @(posedge clk);
        #1;
        in_valid = v;
        x        = value;
    endtask

    task automatic drain_pipeline();
        repeat (4) drive_cycle(1'b0, 16'h0000);
    endtask

    task automatic run_random_stream(input int n_cycles, input bit full_rate);
        logic [31:0] r;
        logic        v;
        for (int i = 0; i < n_cycles; i++) begin
            r = $random(seed);
            v = full_rate ? 1'b1 : r[16];  // About half density otherwise
            drive_cycle(v, r[15:0]);
        end
    endtask

    // Drives one sample and counts edges until out_valid shows up
    task automatic measure_latency(input logic [15:0] value);
        int n;
        bit seen;
        n    = 0;
        seen = 0;
        drive_cycle(1'b1, value);
        while (!seen && n < 10) begin
            drive_cycle(1'b0, 16'h0000);
            n++;
            if (out_valid === 1'b1) begin
                seen = 1;
            end
        end
        if (!seen) begin
            err_count++;
            $display("out_valid never rose after a single in_valid");
        end else if (n != 3) begin
            err_count++;
            $display("out_valid rose %0d cycles after in_valid instead of 3", n);
        end
    endtask

    task automatic check_idle(input int n_cycles);
        for (int i = 0; i < n_cycles; i++) begin
            drive_cycle(1'b0, 16'h0000);
            if (out_valid !== 1'b0) begin
                err_count++;
                $display("out_valid high with no sample in flight at cycle %0d", cycle_count);
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_count++;
            $display("[PASS] %s", name);
        end else begin
            fail_count++;
            $display("[FAIL] %s (%0d errors)", name, err_count - errs_before);
        end
    endtask

    task automatic check_outputs();
        logic [31:0] exp;
        if (out_valid !== pipe_v[2]) begin
            err_count++;
            if (pipe_v[2]) begin
                $display("Missing out_valid at cycle %0d", cycle_count);
            end else begin
                $display("Unexpected out_valid at cycle %0d", cycle_count);
            end
        end else if (pipe_v[2]) begin
            for (int l = 0; l < csd_pkg::num_lanes; l++) begin
                exp = expected_product(pipe_x[2], coef[l]);
                if (y_all[l] !== exp) begin
                    err_count++;
                    $display("** Error: y%0d expected %h, got %h (x = %h)",
                             l, exp, y_all[l], pipe_x[2]);
                end
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Model shifts inputs in at each edge and compares outputs mid-cycle
    initial begin
        for (int i = 0; i < 3; i++) begin
            pipe_v[i] = 1'b0;
            pipe_x[i] = '0;
        end
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                for (int i = 0; i < 3; i++) begin
                    pipe_v[i] = 1'b0;
                end
            end else begin
                pipe_v[2] = pipe_v[1];
                pipe_x[2] = pipe_x[1];
                pipe_v[1] = pipe_v[0];
                pipe_x[1] = pipe_x[0];
                pipe_v[0] = in_valid;
                pipe_x[0] = x;
            end
            @(negedge clk);
            check_outputs();
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped at the cycle limit of %0d", cycle_limit);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        seed       = 82;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        x          = '0;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        corners    = '{16'h8000, 16'h7fff, 16'h0000, 16'hffff, 16'h0001};
        coef[0]    = coef_from_masks(csd_pkg::lane0_pos, csd_pkg::lane0_neg);
        coef[1]    = coef_from_masks(csd_pkg::lane1_pos, csd_pkg::lane1_neg);
        coef[2]    = coef_from_masks(csd_pkg::lane2_pos, csd_pkg::lane2_neg);
        coef[3]    = coef_from_masks(csd_pkg::lane3_pos, csd_pkg::lane3_neg);

        test_start = err_count;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_idle(5);
        measure_latency(16'h1234);
        drain_pipeline();
        finish_test("latency after reset", test_start);

        test_start = err_count;
        run_random_stream(200, 1'b1);
        drain_pipeline();
        finish_test("random samples at full rate", test_start);

        test_start = err_count;
        for (int i = 0; i < 5; i++) begin
            drive_cycle(1'b1, corners[i]);
        end
        drain_pipeline();
        finish_test("corner samples", test_start);

        test_start = err_count;
        run_random_stream(200, 1'b0);
        drain_pipeline();
        finish_test("random in_valid density", test_start);

        test_start = err_count;
        run_random_stream(12, 1'b1);
        @(posedge clk);
        #1;
        rst_n    = 1'b0;  // Samples still in flight
        in_valid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (out_valid !== 1'b0) begin
            err_count++;
            $display("out_valid high in the cycle after reset");
        end
        check_idle(4);
        measure_latency(16'hbeef);
        drain_pipeline();
        finish_test("reset during stream", test_start);

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: sources.f
source/csd_pkg.sv
source/term_gen.sv
source/csa_tree.sv
source/carry_prop_stage.sv
source/csd_mult_bank.sv
verification/tb_csd_mult_bank.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f sources.f --top-module tb_csd_mult_bank --Mdir obj_dir
	./obj_dir/Vtb_csd_mult_bank | tee /dev/stderr | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
